// ==== rtl/cluster_pkg.sv ====
/*
 * Mini cluster package
 * Cluster sizes, peripheral register offsets and the CLINT data word views
 */

`default_nettype none

package cluster_pkg;

  // Cluster dimensions
  localparam int unsigned NrCores      = 4;
  localparam int unsigned CoreIdxWidth = $clog2(NrCores);

  // Narrow port widths, the hart id shares the data width
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned MaskWidth = DataWidth / 2;

  // Peripheral register map
  localparam logic [AddrWidth-1:0] EntryPointOffset = 16'h0000;
  localparam logic [AddrWidth-1:0] ClintMsipOffset  = 16'h0004;

  // Set/clear view of a CLINT write, clear mask in the upper half
  typedef struct packed {
    logic [MaskWidth-1:0] clr_mask;
    logic [MaskWidth-1:0] set_mask;
  } clint_ctl_t;

  // One data word, read either as a plain value or as set/clear masks
  typedef union packed {
    logic [DataWidth-1:0] raw;
    clint_ctl_t           ctl;
  } clint_word_u;

endpackage

`default_nettype wire

// ==== rtl/cluster_periph_regs.sv ====
/*
 * Cluster peripheral registers
 * Boot entry-point scratch register and CLINT software interrupt bits
 */

`timescale 1ns/1ps
`default_nettype none

module cluster_periph_regs import cluster_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  // Narrow inbound request
  input  wire logic                 in_req_valid_i,
  output logic                      in_req_ready_o,
  input  wire logic                 in_we_i,
  input  wire logic [AddrWidth-1:0] in_addr_i,
  input  wire logic [DataWidth-1:0] in_wdata_i,
  // Narrow inbound response
  output logic                      in_rsp_valid_o,
  input  wire logic                 in_rsp_ready_i,
  output logic [DataWidth-1:0]      in_rdata_o,
  output logic                      in_err_o,
  // Towards the cores
  output logic [DataWidth-1:0]      entry_point_o,
  output logic [NrCores-1:0]        msip_o
);

  logic                 accept;
  logic                 hit_entry;
  logic                 hit_msip;
  clint_word_u          wr_word;
  clint_word_u          rd_word;
  logic [NrCores-1:0]   msip_next;

  logic                 rsp_valid_q;
  logic [DataWidth-1:0] rdata_q;
  logic                 err_q;
  logic [DataWidth-1:0] entry_point_q;
  logic [NrCores-1:0]   msip_q;

  // One outstanding request, a held response blocks the next one
  assign in_req_ready_o = ~rsp_valid_q;
  assign accept         = in_req_valid_i & in_req_ready_o;

  assign hit_entry = (in_addr_i == EntryPointOffset);
  assign hit_msip  = (in_addr_i == ClintMsipOffset);

  assign wr_word.raw = in_wdata_i;

  // Old bits minus the clear mask plus the set mask
  assign msip_next = (msip_q & ~wr_word.ctl.clr_mask[NrCores-1:0])
                   | wr_word.ctl.set_mask[NrCores-1:0];

  // Read mux, writes and misses return zero
  always_comb begin
    rd_word.raw = '0;
    if (!in_we_i) begin
      if (hit_entry) begin
        rd_word.raw = entry_point_q;
      end else if (hit_msip) begin
        rd_word.raw = DataWidth'(msip_q);
      end
    end
  end

  // Register updates at the acceptance edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      entry_point_q <= '0;
      msip_q        <= '0;
    end else if (accept && in_we_i) begin
      if (hit_entry) begin
        entry_point_q <= wr_word.raw;
      end
      if (hit_msip) begin
        msip_q <= msip_next;
      end
    end
  end

  // Pending response flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (in_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Response payload, captured with the request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_word.raw;
      err_q   <= ~(hit_entry | hit_msip);
    end
  end

  assign in_rsp_valid_o = rsp_valid_q;
  assign in_rdata_o     = rdata_q;
  assign in_err_o       = err_q;
  assign entry_point_o  = entry_point_q;
  assign msip_o         = msip_q;

  // A stalled response keeps its flag and payload
  property p_rsp_hold;
    @(posedge clk_i) disable iff (reset_i)
      (in_rsp_valid_o && !in_rsp_ready_i)
      |=> (in_rsp_valid_o && $stable(in_rdata_o) && $stable(in_err_o));
  endproperty
  assert property (p_rsp_hold)
    else $error("inbound response changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/hart_wakeup_unit.sv ====
/*
 * Hart wakeup unit
 * Turns a rising msip bit into exactly one boot request
 */

`timescale 1ns/1ps
`default_nettype none

module hart_wakeup_unit import cluster_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire logic                 msip_i,
  input  wire logic [DataWidth-1:0] entry_point_i,
  // Boot request towards the arbiter
  output logic                      boot_valid_o,
  input  wire logic                 boot_ready_i,
  output logic [DataWidth-1:0]      boot_addr_o
);

  logic                 msip_q;
  logic                 msip_rise;
  logic                 pending_q;
  logic                 boot_done;
  logic [DataWidth-1:0] boot_addr_q;

  assign msip_rise = msip_i & ~msip_q;
  assign boot_done = pending_q & boot_ready_i;

  // Previous msip value for edge detection
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      msip_q <= 1'b0;
    end else begin
      msip_q <= msip_i;
    end
  end

  // Edges seen while a request is open are dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (boot_done) begin
      pending_q <= 1'b0;
    end else if (msip_rise) begin
      pending_q <= 1'b1;
    end
  end

  // Entry point as seen at the interrupt edge
  always_ff @(posedge clk_i) begin
    if (msip_rise && !pending_q) begin
      boot_addr_q <= entry_point_i;
    end
  end

  assign boot_valid_o = pending_q;
  assign boot_addr_o  = boot_addr_q;

  property p_boot_hold;
    @(posedge clk_i) disable iff (reset_i)
      (boot_valid_o && !boot_ready_i) |=> (boot_valid_o && $stable(boot_addr_o));
  endproperty
  assert property (p_boot_hold)
    else $error("boot address changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/narrow_out_arbiter.sv ====
/*
 * Narrow outbound arbiter
 * Round-robin merge of the per-core boot requests, adds the hart id
 */

`timescale 1ns/1ps
`default_nettype none

module narrow_out_arbiter import cluster_pkg::*; (
  input  wire logic                              clk_i,
  input  wire logic                              reset_i,
  input  wire logic [DataWidth-1:0]              hart_base_id_i,
  // Per-core requests
  input  wire logic [NrCores-1:0]                req_valid_i,
  output logic [NrCores-1:0]                     req_ready_o,
  input  wire logic [NrCores-1:0][DataWidth-1:0] req_addr_i,
  // Outbound port
  output logic                                   out_valid_o,
  input  wire logic                              out_ready_i,
  output logic [DataWidth-1:0]                   out_hart_o,
  output logic [DataWidth-1:0]                   out_addr_o
);

  logic [CoreIdxWidth-1:0] rr_ptr_q;
  logic [CoreIdxWidth-1:0] rr_idx;
  logic [CoreIdxWidth-1:0] gnt_idx;
  logic [CoreIdxWidth-1:0] lock_idx_q;
  logic                    lock_q;
  logic                    rr_found;
  logic                    out_xfer;

  // First requester at or after the pointer
  always_comb begin
    int unsigned cand;
    rr_found = 1'b0;
    rr_idx   = rr_ptr_q;
    for (int unsigned i = 0; i < NrCores; i++) begin
      cand = (rr_ptr_q + i) % NrCores;
      if (!rr_found && req_valid_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = CoreIdxWidth'(cand);
      end
    end
  end

  // A stalled grant stays put even if another core starts requesting
  assign gnt_idx     = lock_q ? lock_idx_q : rr_idx;
  assign out_valid_o = rr_found;
  assign out_xfer    = out_valid_o & out_ready_i;
  assign out_addr_o  = req_addr_i[gnt_idx];
  assign out_hart_o  = hart_base_id_i + DataWidth'(gnt_idx);

  always_comb begin
    req_ready_o = '0;
    req_ready_o[gnt_idx] = out_xfer;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
      lock_q   <= 1'b0;
    end else begin
      lock_q <= out_valid_o & ~out_ready_i;
      if (out_xfer) begin
        rr_ptr_q <= CoreIdxWidth'((32'(gnt_idx) + 32'd1) % NrCores);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    lock_idx_q <= gnt_idx;
  end

  // Ready goes to at most one core, and only to one that is requesting
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(req_ready_o) && ((req_ready_o & ~req_valid_i) == '0))
    else $error("grant to more than one core or to an idle core");

endmodule

`default_nettype wire

// ==== rtl/mini_cluster.sv ====
/*
 * Mini compute cluster
 * Peripheral registers, per-core wakeup logic and the outbound arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module mini_cluster import cluster_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire logic [DataWidth-1:0] hart_base_id_i,
  // Narrow inbound request
  input  wire logic                 in_req_valid_i,
  output logic                      in_req_ready_o,
  input  wire logic                 in_we_i,
  input  wire logic [AddrWidth-1:0] in_addr_i,
  input  wire logic [DataWidth-1:0] in_wdata_i,
  // Narrow inbound response
  output logic                      in_rsp_valid_o,
  input  wire logic                 in_rsp_ready_i,
  output logic [DataWidth-1:0]      in_rdata_o,
  output logic                      in_err_o,
  // Narrow outbound boot requests
  output logic                      out_valid_o,
  input  wire logic                 out_ready_i,
  output logic [DataWidth-1:0]      out_hart_o,
  output logic [DataWidth-1:0]      out_addr_o
);

  logic [DataWidth-1:0]              entry_point;
  logic [NrCores-1:0]                msip;
  logic [NrCores-1:0]                boot_valid;
  logic [NrCores-1:0]                boot_ready;
  logic [NrCores-1:0][DataWidth-1:0] boot_addr;

  cluster_periph_regs u_periph_regs (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .in_req_valid_i (in_req_valid_i),
    .in_req_ready_o (in_req_ready_o),
    .in_we_i        (in_we_i),
    .in_addr_i      (in_addr_i),
    .in_wdata_i     (in_wdata_i),
    .in_rsp_valid_o (in_rsp_valid_o),
    .in_rsp_ready_i (in_rsp_ready_i),
    .in_rdata_o     (in_rdata_o),
    .in_err_o       (in_err_o),
    .entry_point_o  (entry_point),
    .msip_o         (msip)
  );

  // One wakeup unit per core
  for (genvar k = 0; k < NrCores; k++) begin : gen_wakeup
    hart_wakeup_unit u_wakeup (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .msip_i        (msip[k]),
      .entry_point_i (entry_point),
      .boot_valid_o  (boot_valid[k]),
      .boot_ready_i  (boot_ready[k]),
      .boot_addr_o   (boot_addr[k])
    );
  end

  narrow_out_arbiter u_out_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .hart_base_id_i (hart_base_id_i),
    .req_valid_i    (boot_valid),
    .req_ready_o    (boot_ready),
    .req_addr_i     (boot_addr),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_hart_o     (out_hart_o),
    .out_addr_o     (out_addr_o)
  );

endmodule

`default_nettype wire

// ==== tests/cluster_vip_tasks.svh ====
/*
 * Cluster VIP tasks
 * Narrow inbound register accesses, cycle waits and the value checker
 */

`ifndef CLUSTER_VIP_TASKS_SVH
`define CLUSTER_VIP_TASKS_SVH

  task automatic check_value(input string name, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] want);
    if (got !== want) begin
      stop_on_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, want));
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  // One inbound access, the response is held back for stall cycles
  task automatic bus_access(input logic we, input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] wdata, input int unsigned stall,
                            output logic [DataWidth-1:0] rdata, output logic err);
    @(negedge clk_i);
    in_req_valid_i = 1'b1;
    in_we_i        = we;
    in_addr_i      = addr;
    in_wdata_i     = wdata;
    while (!in_req_ready_o) begin
      @(negedge clk_i);
    end
    // Accepted at the rising edge just passed
    @(negedge clk_i);
    in_req_valid_i = 1'b0;
    if (stall != 0) begin
      in_rsp_ready_i = 1'b0;
    end
    check_value("in_rsp_valid_o", 32'(in_rsp_valid_o), 32'd1);
    rdata = in_rdata_o;
    err   = in_err_o;
    for (int unsigned i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check_value("in_rsp_valid_o", 32'(in_rsp_valid_o), 32'd1);
      check_value("in_req_ready_o", 32'(in_req_ready_o), 32'd0);
      check_value("in_rdata_o", in_rdata_o, rdata);
      check_value("in_err_o", 32'(in_err_o), 32'(err));
    end
    in_rsp_ready_i = 1'b1;
  endtask

  task automatic write_reg(input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, output logic err);
    logic [DataWidth-1:0] unused_rdata;
    bus_access(1'b1, addr, wdata, 0, unused_rdata, err);
  endtask

  task automatic read_reg(input logic [AddrWidth-1:0] addr,
                          output logic [DataWidth-1:0] rdata, output logic err);
    bus_access(1'b0, addr, '0, 0, rdata, err);
  endtask

`endif

// ==== tests/tb_mini_cluster.sv ====
/*
 * Mini cluster testbench
 * Boots cores through the CLINT and checks the outbound boot requests
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mini_cluster import cluster_pkg::*; ();

  localparam logic [DataWidth-1:0] HartBase = 32'h0000_0010;
  localparam logic [31:0]          Seed     = 32'h4a67_4edc;
  // 70 register accesses, drains and idle waits in the sequence below
  localparam int unsigned NumOps    = 70;
  localparam int unsigned MaxCycles = 40 * NumOps;

  logic clk_i, reset_i, in_req_valid_i, in_req_ready_o, in_we_i;
  logic in_rsp_valid_o, in_rsp_ready_i, in_err_o, out_valid_o, out_ready_i;
  logic [AddrWidth-1:0] in_addr_i;
  logic [DataWidth-1:0] hart_base_id_i, in_wdata_i, in_rdata_o, out_hart_o, out_addr_o;

  // Reference model state, one queue entry is {hart, addr}
  logic [DataWidth-1:0]   model_entry;
  logic [NrCores-1:0]     model_msip;
  int unsigned            model_ptr;
  logic [2*DataWidth-1:0] exp_q[$];
  logic [31:0]            rand_state;
  logic [31:0]            stall_state;
  logic                   stall_en;
  logic                   hold_out;
  int unsigned            cycle_cnt;

  mini_cluster u_mini_cluster (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .hart_base_id_i (hart_base_id_i),
    .in_req_valid_i (in_req_valid_i),
    .in_req_ready_o (in_req_ready_o),
    .in_we_i        (in_we_i),
    .in_addr_i      (in_addr_i),
    .in_wdata_i     (in_wdata_i),
    .in_rsp_valid_o (in_rsp_valid_o),
    .in_rsp_ready_i (in_rsp_ready_i),
    .in_rdata_o     (in_rdata_o),
    .in_err_o       (in_err_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_hart_o     (out_hart_o),
    .out_addr_o     (out_addr_o)
  );

  `include "cluster_vip_tasks.svh"

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    rand_state = lcg_step(rand_state);
    return rand_state;
  endfunction

  // Expected boot requests of one CLINT write, pushed in grant order
  function automatic void expected_boots(input clint_word_u word);
    logic [NrCores-1:0] next_msip;
    logic [NrCores-1:0] rise;
    int unsigned        core;
    int unsigned        next_ptr;
    next_msip = model_msip;
    next_ptr  = model_ptr;
    for (int unsigned k = 0; k < NrCores; k++) begin
      if (word.ctl.set_mask[k]) begin
        next_msip[k] = 1'b1;
      end else if (word.ctl.clr_mask[k]) begin
        next_msip[k] = 1'b0;
      end
    end
    // Only a 0 to 1 change wakes a core
    rise = next_msip & ~model_msip;
    for (int unsigned i = 0; i < NrCores; i++) begin
      core = (model_ptr + i) % NrCores;
      if (rise[core]) begin
        exp_q.push_back({hart_base_id_i + DataWidth'(core), model_entry});
        next_ptr = (core + 1) % NrCores;
      end
    end
    model_msip = next_msip;
    model_ptr  = next_ptr;
  endfunction

  task automatic expect_read(input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] want_data, input logic want_err);
    logic [DataWidth-1:0] data;
    logic                 err;
    read_reg(addr, data, err);
    check_value("in_rdata_o", data, want_data);
    check_value("in_err_o", 32'(err), 32'(want_err));
  endtask

  task automatic write_entry(input logic [DataWidth-1:0] value);
    logic err;
    model_entry = value;
    write_reg(EntryPointOffset, value, err);
    check_value("in_err_o", 32'(err), 32'd0);
  endtask

  task automatic write_clint(input logic [NrCores-1:0] clr_bits,
                             input logic [NrCores-1:0] set_bits);
    clint_word_u word;
    logic        err;
    word.ctl.clr_mask = MaskWidth'(clr_bits);
    word.ctl.set_mask = MaskWidth'(set_bits);
    expected_boots(word);
    write_reg(ClintMsipOffset, word.raw, err);
    check_value("in_err_o", 32'(err), 32'd0);
  endtask

  // Idle cycles after the last request let a spurious one show up
  task automatic drain_boots();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    wait_cycles(6);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Random back-pressure on the outbound port, or a full stall
  initial begin
    out_ready_i = 1'b1;
    stall_state = Seed;
    forever begin
      @(negedge clk_i);
      stall_state = lcg_step(stall_state);
      out_ready_i = hold_out ? 1'b0 : (stall_en ? stall_state[16] : 1'b1);
    end
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt > MaxCycles) begin
        stop_on_error("timeout, the test sequence did not finish in time");
      end
    end
  end

  // Scoreboard, sampled at the rising edge where the transfer happens
  initial begin
    logic                   hold;
    logic [DataWidth-1:0]   hold_hart;
    logic [DataWidth-1:0]   hold_addr;
    logic [2*DataWidth-1:0] want;
    hold = 1'b0;
    forever begin
      @(posedge clk_i);
      if (!reset_i && hold) begin
        check_value("out_valid_o", 32'(out_valid_o), 32'd1);
        check_value("out_hart_o", out_hart_o, hold_hart);
        check_value("out_addr_o", out_addr_o, hold_addr);
      end
      if (!reset_i && out_valid_o && exp_q.size() == 0) begin
        stop_on_error("boot request on the outbound port where none was expected");
      end else if (!reset_i && out_valid_o && out_ready_i) begin
        want = exp_q.pop_front();
        check_value("out_hart_o", out_hart_o, want[2*DataWidth-1:DataWidth]);
        check_value("out_addr_o", out_addr_o, want[DataWidth-1:0]);
      end
      hold      = !reset_i && out_valid_o && !out_ready_i;
      hold_hart = out_hart_o;
      hold_addr = out_addr_o;
    end
  end

  initial begin
    logic [DataWidth-1:0] rdata;
    logic                 err;
    logic [DataWidth-1:0] value;
    logic [NrCores-1:0]   mask;
    int unsigned          idx;
    reset_i        = 1'b1;
    hart_base_id_i = HartBase;
    in_req_valid_i = 1'b0;
    in_we_i        = 1'b0;
    in_addr_i      = '0;
    in_wdata_i     = '0;
    in_rsp_ready_i = 1'b1;
    rand_state     = Seed;
    stall_en       = 1'b0;
    hold_out       = 1'b0;
    model_entry    = '0;
    model_msip     = '0;
    model_ptr      = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Cleared registers, no core wakes up
    expect_read(EntryPointOffset, 32'd0, 1'b0);
    expect_read(ClintMsipOffset, 32'd0, 1'b0);
    wait_cycles(8);

    repeat (3) begin
      write_entry(next_random());
      expect_read(EntryPointOffset, model_entry, 1'b0);
    end
    expect_read(16'h0008, 32'd0, 1'b1);
    write_reg(16'h0010, next_random(), err);
    check_value("in_err_o", 32'(err), 32'd1);
    expect_read(EntryPointOffset, model_entry, 1'b0);
    expect_read(ClintMsipOffset, 32'd0, 1'b0);

    // One core at a time
    write_entry(next_random());
    repeat (NrCores) begin
      idx = (next_random() >> 16) % NrCores;
      write_clint('0, NrCores'(1) << idx);
      drain_boots();
      expect_read(ClintMsipOffset, DataWidth'(NrCores'(1) << idx), 1'b0);
      write_clint(NrCores'(1) << idx, '0);
      expect_read(ClintMsipOffset, 32'd0, 1'b0);
    end

    // Several cores at once under outbound back-pressure
    repeat (3) begin
      write_entry(next_random());
      value = next_random();
      mask  = value[16 +: NrCores];
      if ($countones(mask) < 2) begin
        mask = ~mask;
      end
      stall_en = 1'b1;
      write_clint('0, mask);
      drain_boots();
      stall_en = 1'b0;
      expect_read(ClintMsipOffset, DataWidth'(mask), 1'b0);
      write_clint(mask, '0);
    end

    // Clear some cores, set all again with a new entry point
    write_entry(next_random());
    write_clint('0, '1);
    drain_boots();
    value = next_random();
    mask  = value[16 +: NrCores];
    if (mask == '0 || mask == '1) begin
      mask = NrCores'(5);
    end
    write_clint(mask, '0);
    write_entry(next_random());
    write_clint('0, '1);
    drain_boots();
    write_clint('0, '1);
    drain_boots();
    // Clear and set in one write keeps these bits high, so no edge
    write_clint('1, ~mask);
    drain_boots();
    expect_read(ClintMsipOffset, DataWidth'(NrCores'(~mask)), 1'b0);

    // A core that starts requesting late must not take over a stalled grant
    write_clint('1, '0);
    idx      = model_ptr;
    hold_out = 1'b1;
    write_clint('0, NrCores'(1) << ((idx + 1) % NrCores));
    write_entry(next_random());
    write_clint('0, NrCores'(1) << idx);
    hold_out = 1'b0;
    drain_boots();

    // Response back-pressure holds off the next request
    bus_access(1'b0, EntryPointOffset, '0, 5, rdata, err);
    check_value("in_rdata_o", rdata, model_entry);
    value       = next_random();
    model_entry = value;
    bus_access(1'b1, EntryPointOffset, value, 3, rdata, err);
    check_value("in_err_o", 32'(err), 32'd0);
    expect_read(EntryPointOffset, value, 1'b0);
    wait_cycles(4);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tests
rtl/cluster_pkg.sv
rtl/cluster_periph_regs.sv
rtl/hart_wakeup_unit.sv
rtl/narrow_out_arbiter.sv
rtl/mini_cluster.sv
tests/tb_mini_cluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mini_cluster
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
